// ==== all.f ====
logic/enc_pkg.sv
logic/enc_input_filter.sv
logic/quad_decoder.sv
logic/position_counter.sv
logic/period_timer.sv
logic/encoder_channel.sv
tests/encoder_channel_tb.sv

// ==== Makefile ====
# Verilator build for the encoder channel testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= encoder_channel_tb
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall --timing
SIM_FLAGS  ?= --binary --timing -j 0
PASS_TEXT  ?= Simulation passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the run passes only if the testbench printed its pass line
sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "sim: pass line found in $(LOG)"; \
	else \
		echo "sim: pass line missing from $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/encoder_channel_tb.sv ====
// directed testbench for the encoder channel that steps the a/b pins, preloads and checks status
`default_nettype none
`timescale 1ns/1ps

module encoder_channel_tb;

    // --------------------
    // timing and sizes
    // --------------------
    localparam int half_period  = 50;           // 100 ns clock
    localparam int drive_delay  = 10;           // inputs change this long after the edge
    localparam int reset_cycles = 10;
    localparam int step_hold    = 12;           // well above the 8-cycle pin-to-position latency
    localparam int max_steps    = 16;           // upper bound of a random step run
    localparam int period_hold  = 40;           // fixed spacing for the period test
    localparam int stall_cycles = int'(enc_pkg::period_max) + 16;
    localparam logic [31:0] rand_seed = 32'ha2b3_af73;

    // rough length of each test in cycles
    localparam int len_reset    = reset_cycles + 4;
    localparam int len_steps    = 2 * max_steps * step_hold + 8;
    localparam int len_preload  = 2 * step_hold + 8;
    localparam int len_overflow = 4 * step_hold + 16;
    localparam int len_glitch   = step_hold + 8;
    localparam int len_fault    = 3 * step_hold + 8;
    localparam int len_period   = 4 * period_hold + stall_cycles + step_hold + 8;
    // twice the summed test lengths
    localparam int timeout_limit = 2 * (len_reset + len_steps + len_preload + len_overflow
                                        + len_glitch + len_fault + len_period);

    // --------------------
    // DUT signals
    // --------------------
    logic                          clk;
    logic                          reset;
    logic                          enc_a;
    logic                          enc_b;
    logic                          set_pos;
    logic [enc_pkg::pos_width-1:0] preload;
    enc_pkg::enc_status_t          status;

    // expected state from the stepping rules
    logic [enc_pkg::pos_width-1:0] exp_pos;
    logic                          exp_ovf;
    logic                          exp_dir;
    logic                          exp_fault;
    logic [1:0]                    line_code;   // {a, b} now on the pins

    int error_count    = 0;
    int errors_at_start = 0;
    int tests_passed   = 0;
    int tests_failed   = 0;
    int cycle_count    = 0;

    encoder_channel u_encoder_channel (
        .clk     (clk),
        .reset   (reset),
        .enc_a   (enc_a),
        .enc_b   (enc_b),
        .set_pos (set_pos),
        .preload (preload),
        .status  (status)
    );

    initial
    begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // cycle limit for a hung test
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit)
        begin
            $display("timeout: the run went past %0d cycles without finishing", timeout_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // --------------------
    // helpers
    // --------------------
    task automatic next_cycle();
        @(posedge clk);
        #(drive_delay);     // drive point where outputs are settled
    endtask

    // forward Gray order 00, 10, 11, 01
    function automatic logic [1:0] next_gray(input logic [1:0] cur, input logic forward);
        logic [1:0] nxt;
        case (cur)
            2'b00:   nxt = forward ? 2'b10 : 2'b01;
            2'b10:   nxt = forward ? 2'b11 : 2'b00;
            2'b11:   nxt = forward ? 2'b01 : 2'b10;
            default: nxt = forward ? 2'b00 : 2'b11;
        endcase
        return nxt;
    endfunction

    // one legal step on the pins plus the matching model update
    task automatic step_encoder(input logic forward, input int hold_cycles = step_hold);
        line_code = next_gray(line_code, forward);
        enc_a     = line_code[1];
        enc_b     = line_code[0];
        if (forward)
        begin
            if (exp_pos == {enc_pkg::pos_width{1'b1}})
                exp_ovf = 1'b1;                 // wrap up
            exp_pos = exp_pos + 1'b1;
        end
        else
        begin
            if (exp_pos == '0)
                exp_ovf = 1'b1;                 // wrap down
            exp_pos = exp_pos - 1'b1;
        end
        exp_dir = forward;
        repeat (hold_cycles) next_cycle();
    endtask

    // one-cycle set_pos strobe
    task automatic load_position(input logic [enc_pkg::pos_width-1:0] value);
        set_pos = 1'b1;
        preload = value;
        next_cycle();
        set_pos = 1'b0;
        next_cycle();
        exp_pos   = value;
        exp_ovf   = 1'b0;
        exp_fault = 1'b0;   // preload also drops the fault
    endtask

    task automatic check_position(input logic [enc_pkg::pos_width-1:0] want_pos,
                                  input logic want_ovf, input string what);
        if (status.position !== want_pos)
        begin
            error_count++;
            $display("FAIL at %0d ns: %s position %h, expected %h",
                     $time, what, status.position, want_pos);
        end
        if (status.overflow !== want_ovf)
        begin
            error_count++;
            $display("FAIL at %0d ns: %s overflow %b, expected %b",
                     $time, what, status.overflow, want_ovf);
        end
    endtask

    task automatic check_flags(input logic want_dir, input logic want_fault,
                               input logic want_stalled, input string what);
        if ({status.dir, status.fault, status.stalled} !== {want_dir, want_fault, want_stalled})
        begin
            error_count++;
            $display("FAIL at %0d ns: %s dir/fault/stalled %b%b%b, expected %b%b%b",
                     $time, what, status.dir, status.fault, status.stalled,
                     want_dir, want_fault, want_stalled);
        end
    endtask

    task automatic check_period(input logic [enc_pkg::period_width-1:0] want_period,
                                input string what);
        if (status.period !== want_period)
        begin
            error_count++;
            $display("FAIL at %0d ns: %s period %0d, expected %0d",
                     $time, what, status.period, want_period);
        end
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = error_count - errors_at_start;
        if (errs == 0)
        begin
            tests_passed++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, errs);
        end
    endtask

    // --------------------
    // tests
    // --------------------
    task automatic reset_and_steps();
        int n;
        int m;
        start_test();
        next_cycle();
        check_position(enc_pkg::pos_midrange, 1'b0, "after reset");
        check_flags(1'b0, 1'b0, 1'b0, "after reset");
        check_period(enc_pkg::period_max, "after reset");   // no motion yet
        n = $urandom_range(max_steps, 1);
        m = $urandom_range(max_steps, 1);
        repeat (n) step_encoder(1'b1);
        check_position(exp_pos, exp_ovf, "forward run");
        check_flags(1'b1, 1'b0, 1'b0, "forward run");
        repeat (m) step_encoder(1'b0);
        check_position(exp_pos, exp_ovf, "backward run");
        check_flags(1'b0, 1'b0, 1'b0, "backward run");
        finish_test("reset and steps");
    endtask

    task automatic preload_moves();
        start_test();
        load_position(enc_pkg::pos_width'($urandom()));
        check_position(exp_pos, exp_ovf, "preload");
        step_encoder(1'b1);
        check_position(exp_pos, exp_ovf, "step after preload");
        finish_test("preload");
    endtask

    task automatic overflow_wraps();
        start_test();
        load_position({enc_pkg::pos_width{1'b1}});
        step_encoder(1'b1);
        check_position('0, 1'b1, "wrap up");
        load_position('0);
        step_encoder(1'b0);
        check_position({enc_pkg::pos_width{1'b1}}, 1'b1, "wrap down");
        load_position(enc_pkg::pos_width'($urandom()));
        check_position(exp_pos, 1'b0, "preload clears overflow");
        finish_test("overflow");
    endtask

    // a pulse shorter than filter_cycles must not reach the decoder
    task automatic glitch_rejected();
        logic [1:0] glitch_code;
        start_test();
        // one line moves a step in the last direction and back
        // a pulse that leaked through would leave dir flipped
        glitch_code = next_gray(line_code, exp_dir);
        enc_a       = glitch_code[1];
        enc_b       = glitch_code[0];
        repeat (2) next_cycle();
        enc_a = line_code[1];
        enc_b = line_code[0];
        repeat (step_hold) next_cycle();
        check_position(exp_pos, exp_ovf, "after glitch");
        check_flags(exp_dir, 1'b0, 1'b0, "after glitch");
        finish_test("glitch filter");
    endtask

    task automatic fault_latch();
        start_test();
        line_code = ~line_code;         // both lines at once so the step is lost
        enc_a     = line_code[1];
        enc_b     = line_code[0];
        exp_fault = 1'b1;
        repeat (step_hold) next_cycle();
        check_position(exp_pos, exp_ovf, "double change");
        check_flags(exp_dir, 1'b1, 1'b0, "double change");
        load_position(enc_pkg::pos_width'($urandom()));
        check_flags(exp_dir, 1'b0, 1'b0, "preload clears fault");
        step_encoder(1'b0);             // still decoding from the new code
        check_position(exp_pos, exp_ovf, "step after fault");
        finish_test("fault");
    endtask

    task automatic period_measure();
        start_test();
        repeat (3) step_encoder(1'b1, period_hold);
        check_period(enc_pkg::period_width'(period_hold), "fixed hold");
        check_flags(1'b1, exp_fault, 1'b0, "fixed hold");
        repeat (stall_cycles) next_cycle();
        check_period(enc_pkg::period_max, "idle");
        check_flags(1'b1, exp_fault, 1'b1, "idle");
        step_encoder(1'b1);
        check_period(enc_pkg::period_max, "step after stall");  // count was saturated
        check_flags(1'b1, exp_fault, 1'b0, "step after stall");
        check_position(exp_pos, exp_ovf, "step after stall");
        finish_test("period");
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial
    begin
        void'($urandom(rand_seed));
        reset     = 1'b1;
        enc_a     = 1'b0;
        enc_b     = 1'b0;
        set_pos   = 1'b0;
        preload   = '0;
        line_code = 2'b00;
        exp_pos   = enc_pkg::pos_midrange;
        exp_ovf   = 1'b0;
        exp_dir   = 1'b0;
        exp_fault = 1'b0;
        repeat (reset_cycles) next_cycle();
        reset = 1'b0;

        reset_and_steps();
        preload_moves();
        overflow_wraps();
        glitch_rejected();
        fault_latch();
        period_measure();

        $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/encoder_channel.sv ====
// top of one quadrature encoder channel: pins in, packed status out; instantiate once per encoder
`default_nettype none
`timescale 1ns/1ps

module encoder_channel (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           enc_a,    // raw encoder pin a
    input  wire                           enc_b,    // raw encoder pin b
    input  wire                           set_pos,  // one-cycle preload strobe
    input  wire  [enc_pkg::pos_width-1:0] preload,  // value for set_pos
    output enc_pkg::enc_status_t          status    // level, valid every cycle
);

    // --------------------
    // internal wiring
    // --------------------
    logic [1:0]                        code;        // filtered {a, b}
    logic                              tick;        // step strobe
    logic                              dir;         // step direction
    logic                              fault;       // illegal transition latched
    logic [enc_pkg::pos_width-1:0]     position;
    logic                              overflow;
    logic [enc_pkg::period_width-1:0]  period;
    logic                              stalled;

    enc_input_filter u_enc_input_filter (
        .clk   (clk),
        .reset (reset),
        .enc_a (enc_a),
        .enc_b (enc_b),
        .code  (code)
    );

    // preload also drops a latched fault
    quad_decoder u_quad_decoder (
        .clk         (clk),
        .reset       (reset),
        .code        (code),
        .clear_fault (set_pos),
        .tick        (tick),
        .dir         (dir),
        .fault       (fault)
    );

    position_counter u_position_counter (
        .clk      (clk),
        .reset    (reset),
        .tick     (tick),
        .dir      (dir),
        .set_pos  (set_pos),
        .preload  (preload),
        .position (position),
        .overflow (overflow)
    );

    period_timer u_period_timer (
        .clk     (clk),
        .reset   (reset),
        .tick    (tick),
        .period  (period),
        .stalled (stalled)
    );

    // --------------------
    // status packing
    // --------------------
    assign status.overflow = overflow;
    assign status.position = position;
    assign status.dir      = dir;       // straight from decoder, no extra delay
    assign status.period   = period;
    assign status.stalled  = stalled;
    assign status.fault    = fault;

endmodule

`default_nettype wire

// ==== logic/period_timer.sv ====
// measures clock cycles between decoder ticks as a velocity estimate, saturating when stalled
`default_nettype none
`timescale 1ns/1ps

module period_timer (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              tick,     // step from the decoder
    output logic [enc_pkg::period_width-1:0] period,   // cycles between last two ticks
    output logic                             stalled   // no tick for period_max cycles
);

    // free-running interval count, restarted on every tick
    logic [enc_pkg::period_width-1:0] cycle_cnt;
    logic                             cnt_full;  // count has hit the ceiling

    assign cnt_full = (cycle_cnt == enc_pkg::period_max);

    // --------------------
    // interval counter
    // --------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            cycle_cnt <= {{(enc_pkg::period_width-1){1'b0}}, 1'b1};
        else if (tick)
            cycle_cnt <= {{(enc_pkg::period_width-1){1'b0}}, 1'b1};  // restart from 1
        else if (!cnt_full)
            cycle_cnt <= cycle_cnt + 1'b1;
        // else hold at period_max until motion resumes
    end

    // --------------------
    // period latch
    // --------------------
    // reset reports period_max since no motion has been seen yet,
    // but stalled stays low until the timer really runs out
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            period  <= enc_pkg::period_max;
            stalled <= 1'b0;
        end
        else if (tick)
        begin
            period  <= cycle_cnt;       // spacing of this tick from the last one
            stalled <= 1'b0;            // moving again
        end
        else if (cnt_full)
        begin
            period  <= enc_pkg::period_max;  // too slow to measure
            stalled <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/position_counter.sv ====
// 24-bit up/down position counter driven by decoder ticks, with preload and sticky overflow
`default_nettype none
`timescale 1ns/1ps

module position_counter (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          tick,      // one step
    input  wire                          dir,       // 1 = count up
    input  wire                          set_pos,   // load preload, clear overflow
    input  wire  [enc_pkg::pos_width-1:0] preload,  // value loaded by set_pos
    output logic [enc_pkg::pos_width-1:0] position, // current count
    output logic                         overflow   // sticky wrap flag
);

    // --------------------
    // wrap detect
    // --------------------
    logic wrap_up;      // step up from all ones
    logic wrap_down;    // step down from zero

    assign wrap_up   = dir & (position == {enc_pkg::pos_width{1'b1}});
    assign wrap_down = ~dir & (position == '0);

    // --------------------
    // counter
    // --------------------
    // preload beats a tick arriving in the same cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            position <= enc_pkg::pos_midrange;  // room to move both ways
            overflow <= 1'b0;
        end
        else if (set_pos)
        begin
            position <= preload;
            overflow <= 1'b0;
        end
        else if (tick)
        begin
            if (dir)
                position <= position + 1'b1;    // wraps modulo 2^24
            else
                position <= position - 1'b1;
            if (wrap_up || wrap_down)
                overflow <= 1'b1;               // held until next preload
        end
    end

endmodule

`default_nettype wire

// ==== logic/quad_decoder.sv ====
// quadrature state machine: turns filtered a/b codes into step ticks, direction and a fault flag
`default_nettype none
`timescale 1ns/1ps

module quad_decoder (
    input  wire        clk,
    input  wire        reset,
    input  wire  [1:0] code,        // filtered {a, b}
    input  wire        clear_fault, // preload strobe, drops a latched fault
    output logic       tick,        // one cycle per valid step
    output logic       dir,         // 1 = a leads b, held between ticks
    output logic       fault        // illegal transition latched
);

    enc_pkg::dec_state_t state;     // decoder state
    logic [1:0] prev_code;          // code seen on the previous cycle

    logic [1:0] code_diff;          // bits that changed since prev cycle
    logic       single_step;        // exactly one bit changed, a legal step
    logic       double_step;        // both bits changed, step lost

    // --------------------
    // transition detect
    // --------------------
    // odd parity of old xor new means one line moved
    assign code_diff   = code ^ prev_code;
    assign single_step = ^code_diff;
    assign double_step = &code_diff;

    assign fault = (state == enc_pkg::st_fault);

    // --------------------
    // state machine
    // --------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= enc_pkg::st_init;
            prev_code <= 2'b00;
            tick      <= 1'b0;
            dir       <= 1'b0;
        end
        else
        begin
            prev_code <= code;      // always remember last code
            tick      <= 1'b0;      // default, strobe only
            case (state)
                enc_pkg::st_init:
                begin
                    // first code becomes the reference, no tick
                    state <= enc_pkg::st_track;
                end
                enc_pkg::st_track,
                enc_pkg::st_fault:
                begin
                    if (single_step)
                    begin
                        tick <= 1'b1;
                        dir  <= code[1] ^ prev_code[0];  // a ^ b_prev
                    end
                    // a new fault wins over a clear in the same cycle
                    if (double_step)
                        state <= enc_pkg::st_fault;
                    else if (clear_fault)
                        state <= enc_pkg::st_track;
                end
                default:
                    state <= enc_pkg::st_init;  // unused encoding, start over
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/enc_input_filter.sv ====
// synchronises and debounces the raw a/b encoder pins; feeds a clean code to the decoder
`default_nettype none
`timescale 1ns/1ps

module enc_input_filter (
    input  wire        clk,
    input  wire        reset,
    input  wire        enc_a,   // raw encoder line a, asynchronous
    input  wire        enc_b,   // raw encoder line b, asynchronous
    output logic [1:0] code     // filtered {a, b}
);

    // --------------------
    // two-flop synchroniser
    // --------------------
    logic [1:0] sync_1;     // first stage, may be metastable
    logic [1:0] sync_2;     // second stage, safe to use

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sync_1 <= 2'b00;
            sync_2 <= 2'b00;
        end
        else
        begin
            sync_1 <= {enc_a, enc_b};
            sync_2 <= sync_1;
        end
    end

    // --------------------
    // stability filter
    // --------------------
    // each line keeps a run count of samples that differ from its output;
    // the output follows only after filter_cycles such samples in a row
    logic [enc_pkg::filter_cnt_width-1:0] run_cnt [2];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            code <= 2'b00;
            for (int i = 0; i < 2; i++)
                run_cnt[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < 2; i++)
            begin
                if (sync_2[i] == code[i])
                    run_cnt[i] <= '0;           // steady, nothing pending
                else if (run_cnt[i] == enc_pkg::filter_cnt_width'(enc_pkg::filter_cycles - 1))
                begin
                    code[i]    <= sync_2[i];    // held long enough, accept
                    run_cnt[i] <= '0;
                end
                else
                    run_cnt[i] <= run_cnt[i] + 1'b1;  // still bouncing or too short
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/enc_pkg.sv ====
// shared widths, reset values, decoder states and the status struct for the encoder channel
`default_nettype none

package enc_pkg;

    // --------------------
    // position counter
    // --------------------
    localparam int pos_width = 24;                          // bits of position count
    localparam logic [pos_width-1:0] pos_midrange = 24'h800000;  // reset value, half range

    // --------------------
    // period timer
    // --------------------
    localparam int period_width = 16;                       // bits of period measurement
    // all ones means the encoder has stalled
    localparam logic [period_width-1:0] period_max = {period_width{1'b1}};

    // --------------------
    // input filter
    // --------------------
    localparam int filter_cycles = 4;                       // equal samples before a change
    localparam int filter_cnt_width = $clog2(filter_cycles); // run counter width

    // decoder state machine
    // st_init waits for a first reference code, so power-up levels give no tick
    // st_fault is sticky until the channel is preloaded again
    typedef enum logic [1:0] {
        st_init  = 2'd0,    // no previous code known yet
        st_track = 2'd1,    // steady decoding
        st_fault = 2'd2     // illegal two-bit change seen, still decoding
    } dec_state_t;

    // status word leaving the channel, valid every cycle
    typedef struct packed {
        logic                    overflow;  // sticky wrap flag, cleared by preload
        logic [pos_width-1:0]    position;  // up/down count of steps
        logic                    dir;       // 1 = a leads b
        logic [period_width-1:0] period;    // cycles between the last two ticks
        logic                    stalled;   // period at maximum, no recent motion
        logic                    fault;     // illegal transition latched
    } enc_status_t;

endpackage

`default_nettype wire
